// File: Makefile
VERILATOR ?= verilator
TOP ?= uartLinkTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
+incdir+src
src/uartFramePkg.sv
src/uartErrorPkg.sv
src/uartTx.sv
src/uartRx.sv
src/rxFifo.sv
src/uartLink.sv
verification/uartLinkChecker.sv
verification/uartLinkTb.sv

// File: src/rxFifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartMacros.svh"

module rxFifo
(
	input wire Clk,
	input wire reset,
	input wire [`UART_DATA_BITS-1:0] byteData,
	input wire byteStrobe,
	input wire rxPop,
	output logic [`UART_DATA_BITS-1:0] rxData,
	output logic rxValid,
	output logic overrun
);
	localparam int depth = `UART_FIFO_DEPTH;
	localparam int ptrWidth = $clog2(depth);
	localparam int cntWidth = $clog2(depth + 1);
	localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(depth - 1);
	localparam logic [cntWidth-1:0] fullCount = cntWidth'(depth);

	logic [`UART_DATA_BITS-1:0] mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;
	logic full;
	logic doWrite;
	logic doPop;

	assign full = (count == fullCount);
	assign doWrite = byteStrobe && !full;
	assign doPop = rxPop && rxValid; // Pop while empty is dropped
	assign overrun = byteStrobe && full;
	assign rxValid = (count != '0);
	assign rxData = mem[rdPtr];

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
			case ({doWrite, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (doWrite)
			mem[wrPtr] <= byteData;
	end

	countInRange: assert property (@(posedge Clk) disable iff (reset) count <= fullCount);

endmodule

`default_nettype wire

// File: src/uartErrorPkg.sv
`default_nettype none

package uartErrorPkg;

	localparam int errWidth = 4;

	// Frame errors from the receiver
	localparam int errBreak = 0;
	localparam int errParity = 1;
	localparam int errFraming = 2;

	// Raised by the receive FIFO
	localparam int errOverrun = 3;

endpackage

`default_nettype wire

// File: src/uartFramePkg.sv
`default_nettype none
`include "uartMacros.svh"

package uartFramePkg;

	localparam int frameLength = 1 + `UART_DATA_BITS + 1 + `UART_STOP_BITS; // Start, data, parity, stop

	typedef enum logic [2:0]
	{
		idle,
		start,
		data,
		parity,
		stop
	} txState;

	typedef enum logic [2:0]
	{
		ready,
		startBit, // First data bit sampled here
		dataBits,
		parityBit,
		stopBits,
		done
	} rxState;

endpackage

`default_nettype wire

// File: src/uartLink.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartMacros.svh"

module uartLink
(
	input wire Clk,
	input wire reset,
	input wire [`UART_DATA_BITS-1:0] txData,
	input wire txStart,
	input wire cts,
	output logic txOut,
	output logic txBusy,
	input wire rxIn,
	output logic rts,
	input wire rxPop,
	output logic [`UART_DATA_BITS-1:0] rxData,
	output logic rxValid,
	output logic [uartErrorPkg::errWidth-1:0] rxError
);
	import uartErrorPkg::*;

	logic [`UART_DATA_BITS-1:0] byteData;
	logic byteStrobe;
	logic [errFraming:errBreak] frameError;
	logic overrun;

	uartTx i_tx
	(
		.Clk(Clk),
		.reset(reset),
		.txData(txData),
		.txStart(txStart),
		.cts(cts),
		.txOut(txOut),
		.txBusy(txBusy)
	);

	uartRx i_rx
	(
		.Clk(Clk),
		.reset(reset),
		.rxIn(rxIn),
		.rts(rts),
		.byteData(byteData),
		.byteStrobe(byteStrobe),
		.frameError(frameError)
	);

	rxFifo i_fifo
	(
		.Clk(Clk),
		.reset(reset),
		.byteData(byteData),
		.byteStrobe(byteStrobe),
		.rxPop(rxPop),
		.rxData(rxData),
		.rxValid(rxValid),
		.overrun(overrun)
	);

	assign rxError[errOverrun] = overrun;
	assign rxError[errFraming:errBreak] = frameError; // Frame errors below overrun

endmodule

`default_nettype wire

// File: src/uartMacros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Frame shape shared by transmitter and receiver
`define UART_DATA_BITS 8
`define UART_STOP_BITS 2

// Receive buffering
`define UART_FIFO_DEPTH 4

`endif

// File: src/uartRx.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartMacros.svh"

module uartRx
(
	input wire Clk,
	input wire reset,
	input wire rxIn,
	output logic rts,
	output logic [`UART_DATA_BITS-1:0] byteData,
	output logic byteStrobe,
	output logic [uartErrorPkg::errFraming:uartErrorPkg::errBreak] frameError
);
	import uartFramePkg::*;
	import uartErrorPkg::*;

	localparam int cntWidth = $clog2(`UART_DATA_BITS);
	localparam logic [cntWidth-1:0] lastData = cntWidth'(`UART_DATA_BITS - 1);
	localparam logic [cntWidth-1:0] lastStop = cntWidth'(`UART_STOP_BITS - 1);

	rxState state;
	logic [cntWidth-1:0] bitCount;
	logic [`UART_DATA_BITS-1:0] dataReg;
	logic [`UART_STOP_BITS-1:0] stopReg;
	logic parityRx;
	logic parityAcc; // Running XOR of data

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= ready;
			bitCount <= '0;
		end
		else
		begin
			case (state)
				ready:
					if (!rxIn)
						state <= startBit;
				startBit:
				begin
					state <= dataBits;
					bitCount <= cntWidth'(1);
				end
				dataBits:
					if (bitCount == lastData)
					begin
						state <= parityBit;
						bitCount <= '0;
					end
					else
						bitCount <= bitCount + 1'b1;
				parityBit:
					state <= stopBits;
				stopBits:
					if (bitCount == lastStop)
						state <= done;
					else
						bitCount <= bitCount + 1'b1;
				default:
					state <= ready; // Done lasts one cycle
			endcase
		end
	end

	// Line sampling, one bit per clock
	always_ff @(posedge Clk)
	begin
		case (state)
			startBit:
			begin
				dataReg <= {dataReg[`UART_DATA_BITS-2:0], rxIn};
				parityAcc <= rxIn;
			end
			dataBits:
			begin
				dataReg <= {dataReg[`UART_DATA_BITS-2:0], rxIn};
				parityAcc <= parityAcc ^ rxIn;
			end
			parityBit:
				parityRx <= rxIn;
			stopBits:
				stopReg <= {stopReg[`UART_STOP_BITS-2:0], rxIn};
			default:
				parityRx <= parityRx;
		endcase
	end

	always_comb
	begin
		frameError = '0;
		byteStrobe = 1'b0;
		if (state == done)
		begin
			frameError[errFraming] = (stopReg != '1);
			frameError[errParity] = (parityRx != parityAcc);
			frameError[errBreak] = (dataReg == '0) && (stopReg != '1);
			byteStrobe = (frameError == '0);
		end
	end

	assign rts = (state == ready);
	assign byteData = dataReg;

	// Not ready from the first data bit through done
	rtsLowOneFrame: assert property (@(posedge Clk) disable iff (reset)
		$fell(rts) |-> !rts [*frameLength] ##1 rts);

endmodule

`default_nettype wire

// File: src/uartTx.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartMacros.svh"

module uartTx
(
	input wire Clk,
	input wire reset,
	input wire [`UART_DATA_BITS-1:0] txData,
	input wire txStart,
	input wire cts,
	output logic txOut,
	output logic txBusy
);
	import uartFramePkg::*;

	localparam int cntWidth = $clog2(`UART_DATA_BITS);
	localparam logic [cntWidth-1:0] lastData = cntWidth'(`UART_DATA_BITS - 1);
	localparam logic [cntWidth-1:0] lastStop = cntWidth'(`UART_STOP_BITS - 1);

	txState state;
	logic [cntWidth-1:0] bitCount; // Shared by data and stop phases
	logic [`UART_DATA_BITS-1:0] dataReg;
	logic accept;

	assign accept = txStart && cts && (state == idle);
	assign txBusy = (state != idle);

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state <= idle;
			bitCount <= '0;
		end
		else
		begin
			case (state)
				idle:
					if (accept)
						state <= start;
				start:
				begin
					state <= data;
					bitCount <= '0;
				end
				data:
					if (bitCount == lastData)
					begin
						state <= parity;
						bitCount <= '0;
					end
					else
						bitCount <= bitCount + 1'b1;
				parity:
					state <= stop;
				stop:
					if (bitCount == lastStop)
						state <= idle;
					else
						bitCount <= bitCount + 1'b1;
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (accept)
			dataReg <= txData;
	end

	always_comb
	begin
		case (state)
			start: txOut = 1'b0;
			data: txOut = dataReg[lastData - bitCount]; // MSB first
			parity: txOut = ^dataReg; // Even parity
			default: txOut = 1'b1;
		endcase
	end

	// Busy spans exactly one frame, then the line rests at least a cycle
	busyOneFrame: assert property (@(posedge Clk) disable iff (reset)
		$rose(txBusy) |-> txBusy [*frameLength] ##1 !txBusy);

endmodule

`default_nettype wire

// File: verification/uartLinkChecker.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartMacros.svh"

module uartLinkChecker
(
	input wire Clk,
	input wire reset,
	input wire [`UART_DATA_BITS-1:0] txData,
	input wire txStart,
	input wire cts,
	input wire txOut,
	input wire txBusy,
	input wire rxIn,
	input wire rts,
	input wire rxPop,
	input wire [`UART_DATA_BITS-1:0] rxData,
	input wire rxValid,
	input wire [uartErrorPkg::errWidth-1:0] rxError,
	output int passCount,
	output int failCount
);
	import uartFramePkg::*;
	import uartErrorPkg::*;

	localparam int waitLimit = 64; // Cycles before a wait gives up

	logic [errWidth-1:0] errSeen; // OR of rxError pulses since armRx
	int rtsLow;

	initial
	begin
		passCount = 0;
		failCount = 0;
		errSeen = '0;
		rtsLow = 0;
	end

	// Error bits are one-cycle pulses, so collect them as they pass
	always @(negedge Clk)
	begin
		if (!reset)
		begin
			errSeen = errSeen | rxError;
			if (!rts)
				rtsLow = rtsLow + 1;
		end
	end

	task automatic reportValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected === actual)
		begin
			passCount++;
			$display("pass  %s", name);
		end
		else
		begin
			failCount++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic reportFailure(input string name, input string what);
		failCount++;
		$display("%s failed: %s", name, what);
	endtask

	task automatic armRx();
		errSeen = '0;
		rtsLow = 0;
	endtask

	// Samples one frame plus one idle cycle of txOut and txBusy
	task automatic checkTx(input string name, input logic [`UART_DATA_BITS-1:0] data,
		input logic expectFrame);
		logic [frameLength:0] outSeen;
		logic [frameLength:0] busySeen;
		logic [frameLength:0] outExp;
		logic [frameLength:0] busyExp;
		int waited;
		int i;
		outSeen = '0;
		busySeen = '0;
		waited = 0;
		if (expectFrame)
		begin
			outExp = {1'b0, data, ^data, {`UART_STOP_BITS{1'b1}}, 1'b1};
			busyExp = {{frameLength{1'b1}}, 1'b0};
			while (!txBusy && waited < waitLimit)
			begin
				@(negedge Clk);
				waited++;
			end
		end
		else
		begin
			outExp = '1; // Line must stay idle
			busyExp = '0;
		end
		if (expectFrame && !txBusy)
			reportFailure(name, "timed out waiting for txBusy after txStart");
		else
		begin
			for (i = 0; i <= frameLength; i++)
			begin
				outSeen = {outSeen[frameLength-1:0], txOut};
				busySeen = {busySeen[frameLength-1:0], txBusy};
				@(negedge Clk);
			end
			reportValue(name, 32'({busyExp, outExp}), 32'({busySeen, outSeen}));
		end
	endtask

	task automatic checkRx(input string name, input logic [errWidth-1:0] expErr);
		int waited;
		waited = 0;
		while (!rts && waited < waitLimit)
		begin
			@(negedge Clk);
			waited++;
		end
		if (!rts)
			reportFailure(name, "timed out waiting for the receiver to return to ready");
		else if (rtsLow != frameLength)
		begin
			failCount++;
			$display("error %s: rts low cycles expected %0d, actual %0d", name, frameLength,
				rtsLow);
		end
		else
			reportValue(name, 32'(expErr), 32'(errSeen));
	endtask

	task automatic checkPop(input string name, input logic [`UART_DATA_BITS-1:0] expected);
		int waited;
		waited = 0;
		while (!rxValid && waited < waitLimit)
		begin
			@(negedge Clk);
			waited++;
		end
		if (!rxValid)
			reportFailure(name, "timed out waiting for rxValid before the pop");
		else
			reportValue(name, 32'(expected), 32'(rxData));
	endtask

	task automatic checkValid(input string name, input logic expected);
		reportValue(name, 32'(expected), 32'(rxValid));
	endtask

	// Packed as txOut, txBusy, rts, rxValid, rxError
	task automatic checkIdle(input string name);
		reportValue(name, 32'({1'b1, 1'b0, 1'b1, 1'b0, {errWidth{1'b0}}}),
			32'({txOut, txBusy, rts, rxValid, rxError}));
	endtask

endmodule

`default_nettype wire

// File: verification/uartLinkTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "uartMacros.svh"

module uartLinkTb;
	import uartFramePkg::*;

	localparam string dataPath = "verification/uartLink_testdata.txt";
	localparam int halfPeriod = 4; // 8 ns clock

	logic Clk;
	logic reset;
	logic [`UART_DATA_BITS-1:0] txData;
	logic txStart;
	logic cts;
	logic rxIn;
	logic rxPop;
	wire txOut;
	wire txBusy;
	wire rts;
	wire [`UART_DATA_BITS-1:0] rxData;
	wire rxValid;
	wire [uartErrorPkg::errWidth-1:0] rxError;
	int passCount;
	int failCount;
	int setupErrors;
	int fd;
	int code;
	string line;

	always #halfPeriod Clk = ~Clk;

	uartLink i_dut
	(
		.Clk(Clk),
		.reset(reset),
		.txData(txData),
		.txStart(txStart),
		.cts(cts),
		.txOut(txOut),
		.txBusy(txBusy),
		.rxIn(rxIn),
		.rts(rts),
		.rxPop(rxPop),
		.rxData(rxData),
		.rxValid(rxValid),
		.rxError(rxError)
	);

	uartLinkChecker i_checker
	(
		.Clk(Clk),
		.reset(reset),
		.txData(txData),
		.txStart(txStart),
		.cts(cts),
		.txOut(txOut),
		.txBusy(txBusy),
		.rxIn(rxIn),
		.rts(rts),
		.rxPop(rxPop),
		.rxData(rxData),
		.rxValid(rxValid),
		.rxError(rxError),
		.passCount(passCount),
		.failCount(failCount)
	);

	task automatic startTx(input logic [`UART_DATA_BITS-1:0] data, input logic ctsLevel);
		@(negedge Clk);
		txData = data;
		cts = ctsLevel;
		txStart = 1'b1;
		@(negedge Clk);
		txStart = 1'b0;
		cts = 1'b1;
	endtask

	// Start, data MSB first, even parity, stop bits, one bit per clock
	task automatic sendFrame(input logic [`UART_DATA_BITS-1:0] data, input logic flip,
		input logic [`UART_STOP_BITS-1:0] stops);
		logic [frameLength-1:0] frame;
		int i;
		frame = {1'b0, data, (^data) ^ flip, stops};
		for (i = frameLength - 1; i >= 0; i--)
		begin
			@(negedge Clk);
			rxIn = frame[i];
		end
		@(negedge Clk);
		rxIn = 1'b1; // Back to idle
	endtask

	task automatic flagBadLine(input string text);
		$display("malformed line in the test data file: %s", text);
		setupErrors++;
	endtask

	task automatic runCommand(input string text);
		string cmd;
		string name;
		int fields;
		logic [`UART_DATA_BITS-1:0] data;
		logic flag;
		logic [`UART_STOP_BITS-1:0] stops;
		logic [uartErrorPkg::errWidth-1:0] expErr;
		fields = $sscanf(text, "%s %s", cmd, name);
		if (fields < 1 || cmd.getc(0) == "#")
			fields = 0; // Blank or comment line
		else if (cmd == "tx")
		begin
			fields = $sscanf(text, "%s %s %h %b", cmd, name, data, flag);
			if (fields != 4)
				flagBadLine(text);
			else
			begin
				startTx(data, flag);
				i_checker.checkTx(name, data, flag);
			end
		end
		else if (cmd == "rx")
		begin
			fields = $sscanf(text, "%s %s %h %b %b %h", cmd, name, data, flag, stops, expErr);
			if (fields != 6)
				flagBadLine(text);
			else
			begin
				i_checker.armRx();
				sendFrame(data, flag, stops);
				i_checker.checkRx(name, expErr);
			end
		end
		else if (cmd == "pop")
		begin
			fields = $sscanf(text, "%s %s %h", cmd, name, data);
			if (fields != 3)
				flagBadLine(text);
			else
			begin
				@(negedge Clk);
				i_checker.checkPop(name, data);
				rxPop = 1'b1;
				@(negedge Clk);
				rxPop = 1'b0;
			end
		end
		else if (cmd == "valid")
		begin
			fields = $sscanf(text, "%s %s %b", cmd, name, flag);
			if (fields != 3)
				flagBadLine(text);
			else
			begin
				@(negedge Clk);
				i_checker.checkValid(name, flag);
			end
		end
		else if (cmd == "idle")
		begin
			if (fields != 2)
				flagBadLine(text);
			else
			begin
				@(negedge Clk);
				i_checker.checkIdle(name);
			end
		end
		else
		begin
			$display("unknown command %s in the test data file", cmd);
			setupErrors++;
		end
	endtask

	initial
	begin
		Clk = 1'b0;
		reset = 1'b1;
		txData = '0;
		txStart = 1'b0;
		cts = 1'b1;
		rxIn = 1'b1;
		rxPop = 1'b0;
		setupErrors = 0;
		repeat (4) @(negedge Clk);
		reset = 1'b0;
		fd = $fopen(dataPath, "r");
		if (fd == 0)
		begin
			$display("could not open the test data file %s", dataPath);
			setupErrors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				code = $fgets(line, fd);
				if (code > 0)
					runCommand(line);
			end
			$fclose(fd);
		end
		repeat (2) @(negedge Clk);
		$display("Tests passed: %0d, failed: %0d", passCount, failCount + setupErrors);
		if (failCount == 0 && setupErrors == 0 && passCount > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/uartLink_testdata.txt
# tx name data(hex) cts(bin) | rx name data(hex) parityFlip(bin) stopBits(bin) expErr(hex)
# pop name expData(hex) | valid name expValid(bin) | idle name
idle afterReset
tx txA5 a5 1
tx tx3c 3c 1
tx txNoCts 5a 0
tx tx00 00 1
rx rxGood 5a 0 11 0
valid goodQueued 1
pop popGood 5a
valid emptyAfterPop 0
rx rxParity c3 1 11 2
valid parityDropped 0
rx rxFraming 81 0 01 4
rx rxBreak 00 0 10 5
rx rxStopZero 00 0 00 5
rx rxParityFraming 7e 1 01 6
valid errorsDropped 0
rx fill1 11 0 11 0
rx fill2 22 0 11 0
rx fill3 33 0 11 0
rx fill4 44 0 11 0
rx overflow 55 0 11 8
pop pop1 11
pop pop2 22
pop pop3 33
valid stillValid 1
pop pop4 44
valid drained 0
idle finalIdle
